// ==== logic/memctl_cfg.svh ====
// Memory controller configuration
`ifndef MEMCTL_CFG_SVH
`define MEMCTL_CFG_SVH

// Memory windows, matched on the top address byte
`define MEMCTL_FLASH_BASE 32'h0000_0000
`define MEMCTL_PSRAM_BASE 32'h0100_0000

// UART block matched on bits 31 to 10, instance in bits 9 to 8
`define MEMCTL_UART_BASE 32'h0200_0000

// Single-page peripherals, matched on bits 31 to 8
`define MEMCTL_GPIO_BASE 32'h0200_1000
`define MEMCTL_TIMER_BASE 32'h0200_2000

// Number of UART instances, 1 to 4
`define MEMCTL_UART_NUM 3

// Serial memory command codes
`define MEMCTL_CMD_READ 8'h03
`define MEMCTL_CMD_WRITE 8'h02

// clk cycles per sclk period, even and at least 2
`define MEMCTL_SCLK_DIV 2

`endif

// ==== logic/memctl_bus_pkg.sv ====
// Core-side bus types
package memctl_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Width of one load or store
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } size_e;

    // Peripheral that answers a strobe
    typedef enum logic [1:0] {
        PERIPH_NONE,
        PERIPH_UART,
        PERIPH_GPIO,
        PERIPH_TIMER
    } periph_e;

    // Bit 2 only marks LBU/LHU, the width is in bits 1 to 0
    function automatic size_e size_from_funct3(input logic [2:0] funct3);
        size_e size;
        case (funct3[1:0])
            2'b00: size = SIZE_BYTE;
            2'b01: size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
        return size;
    endfunction

endpackage

// ==== logic/memctl_spi_pkg.sv ====
// SPI-side transfer types
package memctl_spi_pkg;

    typedef logic [23:0] dev_addr_t;

    // Data phase length, 8, 16 or 32
    typedef logic [5:0] bit_count_t;

    typedef enum logic {
        TARGET_FLASH,
        TARGET_PSRAM
    } target_e;

    typedef enum logic {
        CTL_IDLE,
        CTL_BUSY
    } ctl_state_e;

    typedef enum logic [2:0] {
        SHIFT_IDLE,
        SHIFT_CMD,
        SHIFT_ADDR,
        SHIFT_DATA,
        SHIFT_DONE
    } shift_state_e;

endpackage

// ==== logic/memctl_ifs.sv ====
// Memory request and SPI transfer interfaces
`timescale 1ns/1ps

// One memory-window access, decoder to access controller
interface mem_req_if
    import memctl_bus_pkg::*, memctl_spi_pkg::*;
();
    logic       valid;
    logic       write;
    target_e    target;
    dev_addr_t  addr;
    // First byte on the wire sits in bits 31 to 24
    word_t      wdata;
    bit_count_t nbits;
    size_e      size;

    modport source (output valid, write, target, addr, wdata, nbits, size);
    modport sink   (input  valid, write, target, addr, wdata, nbits, size);
endinterface

// One serial transfer, access controller to shifter
interface spi_xfer_if
    import memctl_bus_pkg::*, memctl_spi_pkg::*;
();
    logic       start;
    logic       write;
    target_e    target;
    dev_addr_t  addr;
    word_t      wdata;
    bit_count_t nbits;
    // Right-aligned, first received byte in bits 7 to 0
    word_t      rdata;
    logic       done;

    modport ctl (
        output start, write, target, addr, wdata, nbits,
        input  rdata, done
    );
    modport shifter (
        input  start, write, target, addr, wdata, nbits,
        output rdata, done
    );
endinterface

// ==== logic/req_decode.sv ====
// Core request decoder
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module req_decode
    import memctl_bus_pkg::*, memctl_spi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      addr,
    input  word_t      wdata,
    input  logic [2:0] funct3,
    input  logic       we,
    input  logic       re,
    mem_req_if.source  req,
    output periph_e    periph_sel,
    output logic [1:0] uart_index
);
    localparam addr_t FLASH_BASE = `MEMCTL_FLASH_BASE;
    localparam addr_t PSRAM_BASE = `MEMCTL_PSRAM_BASE;
    localparam addr_t UART_BASE  = `MEMCTL_UART_BASE;
    localparam addr_t GPIO_BASE  = `MEMCTL_GPIO_BASE;
    localparam addr_t TIMER_BASE = `MEMCTL_TIMER_BASE;

    logic    strobe;
    logic    flash_hit;
    logic    psram_hit;
    logic    uart_hit;
    logic    gpio_hit;
    logic    timer_hit;
    size_e   size;
    periph_e periph_hit;

    assign strobe    = we | re;
    assign flash_hit = addr[31:24] == FLASH_BASE[31:24];
    assign psram_hit = addr[31:24] == PSRAM_BASE[31:24];
    assign uart_hit  = (addr[31:10] == UART_BASE[31:10]) && (int'(addr[9:8]) < `MEMCTL_UART_NUM);
    assign gpio_hit  = addr[31:8] == GPIO_BASE[31:8];
    assign timer_hit = addr[31:8] == TIMER_BASE[31:8];

    assign size = size_from_funct3(funct3);

    // Memory windows go to the access controller in the strobe cycle
    assign req.valid  = strobe & (flash_hit | psram_hit);
    assign req.write  = we;
    assign req.target = psram_hit ? TARGET_PSRAM : TARGET_FLASH;
    assign req.addr   = addr[23:0];
    assign req.size   = size;

    // Stores go out least significant byte first
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                req.wdata = {wdata[7:0], 24'h0};
                req.nbits = 6'd8;
            end
            SIZE_HALF: begin
                req.wdata = {wdata[7:0], wdata[15:8], 16'h0};
                req.nbits = 6'd16;
            end
            default: begin
                req.wdata = {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24]};
                req.nbits = 6'd32;
            end
        endcase
    end

    always_comb begin
        if (uart_hit) begin
            periph_hit = PERIPH_UART;
        end else if (gpio_hit) begin
            periph_hit = PERIPH_GPIO;
        end else if (timer_hit) begin
            periph_hit = PERIPH_TIMER;
        end else begin
            periph_hit = PERIPH_NONE;
        end
    end

    // Peripheral selection lives for the cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            periph_sel <= PERIPH_NONE;
            uart_index <= 2'd0;
        end else begin
            periph_sel <= strobe ? periph_hit : PERIPH_NONE;
            uart_index <= addr[9:8];
        end
    end

    // Overlapping windows in the address map would start two responses
    a_one_window: assert property (@(posedge clk) disable iff (!rst_n)
        strobe |-> $onehot0({flash_hit, psram_hit, uart_hit, gpio_hit, timer_hit}))
        else $error("req_decode: address %08h hits more than one window", addr);

endmodule

// ==== logic/access_ctl.sv ====
// Memory access sequencer
`timescale 1ns/1ps

module access_ctl
    import memctl_bus_pkg::*, memctl_spi_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    mem_req_if.sink  req,
    spi_xfer_if.ctl  xfer,
    output logic     mem_done,
    output word_t    raw_data,
    output size_e    size
);
    ctl_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CTL_IDLE;
            xfer.start <= 1'b0;
            mem_done   <= 1'b0;
        end else begin
            xfer.start <= 1'b0;
            mem_done   <= 1'b0;
            case (state)
                CTL_IDLE: begin
                    if (req.valid) begin
                        xfer.start <= 1'b1;
                        state      <= CTL_BUSY;
                    end
                end
                CTL_BUSY: begin
                    // Requests arriving here are dropped
                    if (xfer.done) begin
                        mem_done <= 1'b1;
                        state    <= CTL_IDLE;
                    end
                end
                default: state <= CTL_IDLE;
            endcase
        end
    end

    // Transfer fields stay stable until done
    always_ff @(posedge clk) begin
        if (state == CTL_IDLE && req.valid) begin
            xfer.write  <= req.write;
            xfer.target <= req.target;
            xfer.addr   <= req.addr;
            xfer.wdata  <= req.wdata;
            xfer.nbits  <= req.nbits;
            size        <= req.size;
        end
        if (state == CTL_BUSY && xfer.done) begin
            raw_data <= xfer.rdata;
        end
    end

    // Core must wait for mem_ready before the next memory strobe
    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> state == CTL_IDLE)
        else $error("access_ctl: memory request while a transfer is running");

    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        xfer.done |-> state == CTL_BUSY)
        else $error("access_ctl: shifter done without an open transfer");

endmodule

// ==== logic/spi_shifter.sv ====
// Single-lane SPI shifter
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module spi_shifter
    import memctl_spi_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    spi_xfer_if.shifter xfer,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso,
    output logic        flash_cs_n,
    output logic        ram_cs_n
);
    localparam int HALF = `MEMCTL_SCLK_DIV / 2;

    shift_state_e state;
    logic [3:0]   div_cnt;
    logic         tick;
    logic         active;
    bit_count_t   bit_cnt;
    bit_count_t   phase_last;
    logic         last_bit;
    logic [7:0]   cmd;
    logic [63:0]  tx_sreg;
    logic [7:0]   rx_byte;
    logic [7:0]   rx_next;

    assign active = (state == SHIFT_CMD) || (state == SHIFT_ADDR) || (state == SHIFT_DATA);
    assign tick   = active && (div_cnt == 4'(HALF - 1));
    assign cmd    = xfer.write ? `MEMCTL_CMD_WRITE : `MEMCTL_CMD_READ;
    assign mosi   = active & tx_sreg[63];
    assign rx_next = {rx_byte[6:0], miso};

    // Last bit index of the current field
    always_comb begin
        case (state)
            SHIFT_CMD:  phase_last = 6'd7;
            SHIFT_ADDR: phase_last = 6'd23;
            default:    phase_last = xfer.nbits - 6'd1;
        endcase
    end
    assign last_bit = bit_cnt == phase_last;

    // sclk half-period counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= 4'd0;
        end else if (!active || tick) begin
            div_cnt <= 4'd0;
        end else begin
            div_cnt <= div_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SHIFT_IDLE;
            bit_cnt    <= '0;
            sclk       <= 1'b0;
            flash_cs_n <= 1'b1;
            ram_cs_n   <= 1'b1;
            xfer.done  <= 1'b0;
        end else begin
            xfer.done <= 1'b0;
            case (state)
                SHIFT_IDLE: begin
                    if (xfer.start) begin
                        state      <= SHIFT_CMD;
                        bit_cnt    <= '0;
                        flash_cs_n <= xfer.target != TARGET_FLASH;
                        ram_cs_n   <= xfer.target != TARGET_PSRAM;
                    end
                end
                SHIFT_DONE: begin
                    xfer.done <= 1'b1;
                    state     <= SHIFT_IDLE;
                end
                default: begin
                    if (tick) begin
                        sclk <= ~sclk;
                        // A falling edge closes the current bit
                        if (sclk) begin
                            if (last_bit) begin
                                bit_cnt <= '0;
                                case (state)
                                    SHIFT_CMD:  state <= SHIFT_ADDR;
                                    SHIFT_ADDR: state <= SHIFT_DATA;
                                    default: begin
                                        state      <= SHIFT_DONE;
                                        flash_cs_n <= 1'b1;
                                        ram_cs_n   <= 1'b1;
                                    end
                                endcase
                            end else begin
                                bit_cnt <= bit_cnt + 6'd1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Command, address and data leave MSB first from one register
    always_ff @(posedge clk) begin
        if (state == SHIFT_IDLE && xfer.start) begin
            tx_sreg    <= {cmd, xfer.addr, xfer.wdata};
            xfer.rdata <= '0;
        end else if (tick) begin
            if (sclk) begin
                tx_sreg <= {tx_sreg[62:0], 1'b0};
            end else if (state == SHIFT_DATA) begin
                rx_byte <= rx_next;
                // Byte n of the data phase lands in bits 8n+7 to 8n
                if (bit_cnt[2:0] == 3'd7) begin
                    xfer.rdata[{bit_cnt[4:3], 3'b000} +: 8] <= rx_next;
                end
            end
        end
    end

    a_one_cs: assert property (@(posedge clk) disable iff (!rst_n)
        flash_cs_n || ram_cs_n)
        else $error("spi_shifter: flash and PSRAM selected together");

endmodule

// ==== logic/rsp_format.sv ====
// Core response formatter
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module rsp_format
    import memctl_bus_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_e                     periph_sel,
    input  logic [1:0]                  uart_index,
    input  word_t [`MEMCTL_UART_NUM-1:0] uart_rdata,
    input  word_t                       gpio_rdata,
    input  word_t                       timer_rdata,
    input  logic                        mem_done,
    input  word_t                       raw_data,
    input  size_e                       size,
    output word_t                       mem_rdata,
    output logic                        mem_ready
);
    logic  mem_valid;
    word_t mem_word;
    word_t load_word;
    word_t periph_word;

    // Byte and halfword loads are zero-extended
    always_comb begin
        case (size)
            SIZE_BYTE: load_word = {24'h0, raw_data[7:0]};
            SIZE_HALF: load_word = {16'h0, raw_data[15:0]};
            default:   load_word = raw_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= mem_done;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_done) begin
            mem_word <= load_word;
        end
    end

    // periph_sel is already one cycle behind the strobe
    always_comb begin
        case (periph_sel)
            PERIPH_UART:  periph_word = uart_rdata[uart_index];
            PERIPH_GPIO:  periph_word = gpio_rdata;
            PERIPH_TIMER: periph_word = timer_rdata;
            default:      periph_word = '0;
        endcase
    end

    assign mem_rdata = (periph_sel != PERIPH_NONE) ? periph_word : mem_word;
    assign mem_ready = mem_valid | (periph_sel != PERIPH_NONE);

endmodule

// ==== logic/mem_ctl_top.sv ====
// Data-side memory controller
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module mem_ctl_top
    import memctl_bus_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  addr_t                         mem_addr,
    input  word_t                         mem_wdata,
    input  logic [2:0]                    mem_flag,
    input  logic                          mem_we,
    input  logic                          mem_re,
    output word_t                         mem_rdata,
    output logic                          mem_ready,
    input  logic [`MEMCTL_UART_NUM*32-1:0] uart_mem_rdata,
    input  word_t                         gpio_mem_rdata,
    input  word_t                         timer_mem_rdata,
    output logic                          flash_cs_n,
    output logic                          ram_cs_n,
    output logic                          spi_sclk,
    output logic                          spi_mosi,
    input  logic                          spi_miso
);
    periph_e    periph_sel;
    logic [1:0] uart_index;
    logic       mem_done;
    word_t      raw_data;
    size_e      size;

    mem_req_if  req_bus ();
    spi_xfer_if xfer_bus ();

    req_decode u_req_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (mem_addr),
        .wdata      (mem_wdata),
        .funct3     (mem_flag),
        .we         (mem_we),
        .re         (mem_re),
        .req        (req_bus.source),
        .periph_sel (periph_sel),
        .uart_index (uart_index)
    );

    access_ctl u_access_ctl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_bus.sink),
        .xfer     (xfer_bus.ctl),
        .mem_done (mem_done),
        .raw_data (raw_data),
        .size     (size)
    );

    spi_shifter u_spi_shifter (
        .clk        (clk),
        .rst_n      (rst_n),
        .xfer       (xfer_bus.shifter),
        .sclk       (spi_sclk),
        .mosi       (spi_mosi),
        .miso       (spi_miso),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n)
    );

    rsp_format u_rsp_format (
        .clk         (clk),
        .rst_n       (rst_n),
        .periph_sel  (periph_sel),
        .uart_index  (uart_index),
        .uart_rdata  (uart_mem_rdata),
        .gpio_rdata  (gpio_mem_rdata),
        .timer_rdata (timer_mem_rdata),
        .mem_done    (mem_done),
        .raw_data    (raw_data),
        .size        (size),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset released on the eighth rising edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== dv/spi_mem_model.sv ====
// Behavioral SPI serial memory
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module spi_mem_model #(
    parameter logic [7:0] FILL = 8'h00
) (
    input  logic cs_n,
    input  logic sclk,
    input  logic mosi,
    output wire  miso
);
    logic [7:0]  mem [0:255];
    logic [31:0] hdr;
    logic [7:0]  wr_byte;
    logic        miso_q;
    int          bit_cnt;
    int          wr_bit;
    int          rd_bit;

    // Only the selected device drives the shared line
    assign miso = cs_n ? 1'bz : miso_q;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i[7:0] * 8'd37) ^ FILL;
        end
        miso_q = 1'b0;
    end

    // Command and address come first, then any bytes to store
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt = 0;
        end else begin
            if (bit_cnt < 32) begin
                hdr = {hdr[30:0], mosi};
            end else if (hdr[31:24] == `MEMCTL_CMD_WRITE) begin
                wr_bit  = bit_cnt - 32;
                wr_byte = {wr_byte[6:0], mosi};
                if (wr_bit[2:0] == 3'd7) begin
                    mem[hdr[7:0] + wr_bit[10:3]] = wr_byte;
                end
            end
            bit_cnt++;
        end
    end

    // Read data goes out MSB first, a new bit after each falling edge
    always @(negedge sclk) begin
        if (!cs_n && bit_cnt >= 32 && hdr[31:24] == `MEMCTL_CMD_READ) begin
            rd_bit = bit_cnt - 32;
            miso_q = mem[hdr[7:0] + rd_bit[10:3]][3'd7 - rd_bit[2:0]];
        end
    end

endmodule

// ==== dv/tb_checker.sv ====
// Response and SPI header checker
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module tb_checker
    import memctl_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t mem_addr,
    input  logic  mem_we,
    input  logic  mem_re,
    input  word_t exp_rdata,
    input  logic  exp_check,
    input  word_t mem_rdata,
    input  logic  mem_ready,
    input  logic  flash_cs_n,
    input  logic  ram_cs_n,
    input  logic  spi_sclk,
    input  logic  spi_mosi,
    output int    errors,
    output int    checked
);
    localparam addr_t FLASH_BASE = `MEMCTL_FLASH_BASE;
    localparam addr_t PSRAM_BASE = `MEMCTL_PSRAM_BASE;

    logic        started;
    logic        pending;
    logic        is_mem;
    logic        is_write;
    logic        to_psram;
    logic        check_q;
    logic        hdr_seen;
    logic        sclk_q;
    logic        cs_q;
    logic        cs_low;
    addr_t       req_addr;
    word_t       exp_q;
    logic [31:0] hdr;
    logic [7:0]  exp_cmd;
    int          latency;
    int          bit_cnt;
    int          entry_errs;

    task automatic report(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
        entry_errs++;
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("MISMATCH at %0t: %s expected %08h got %08h", $time, name, exp, got);
        errors++;
        entry_errs++;
    endtask

    // First 32 bits after chip select falls hold command and address
    task automatic check_header();
        exp_cmd = is_write ? `MEMCTL_CMD_WRITE : `MEMCTL_CMD_READ;
        if (!(pending && is_mem)) begin
            report("SPI transfer without a memory request");
        end else begin
            if (hdr[31:24] !== exp_cmd) begin
                mismatch("spi_mosi command", {24'h0, exp_cmd}, {24'h0, hdr[31:24]});
            end
            if (hdr[23:0] !== req_addr[23:0]) begin
                mismatch("spi_mosi address", {8'h0, req_addr[23:0]}, {8'h0, hdr[23:0]});
            end
            hdr_seen = 1'b1;
        end
    endtask

    task automatic finish_entry();
        if (!pending) begin
            report("mem_ready pulsed with no request open");
        end else begin
            if (!is_mem && latency != 1) begin
                report($sformatf("peripheral mem_ready came %0d cycles after the strobe", latency));
            end
            if (is_mem && !hdr_seen) begin
                report("memory access finished without an SPI transfer");
            end
            if (check_q && mem_rdata !== exp_q) begin
                mismatch("mem_rdata", exp_q, mem_rdata);
            end
            $display("entry %0d %s %08h %s", checked, is_write ? "store" : "load",
                     req_addr, entry_errs == 0 ? "ok" : "error");
            checked++;
            pending = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            errors   = 0;
            checked  = 0;
            started  = 1'b0;
            pending  = 1'b0;
            hdr_seen = 1'b0;
            sclk_q   = 1'b0;
            cs_q     = 1'b0;
            latency  = 0;
            bit_cnt  = 0;
        end else begin
            cs_low = !flash_cs_n || !ram_cs_n;
            // Idle outputs until the first strobe
            if (!started && (mem_ready || cs_low)) begin
                report("mem_ready high or chip select low before the first strobe");
            end
            if (!flash_cs_n && !ram_cs_n) begin
                report("flash and PSRAM chip selects low together");
            end else if (cs_low && !(pending && is_mem)) begin
                report("chip select low without a memory request");
            end else if (cs_low && (to_psram ? !flash_cs_n : !ram_cs_n)) begin
                report("chip select of the wrong device low");
            end
            if (cs_low && !cs_q) begin
                bit_cnt = 0;
            end
            // mosi is stable while sclk rises
            if (cs_low && spi_sclk && !sclk_q && bit_cnt < 32) begin
                hdr = {hdr[30:0], spi_mosi};
                bit_cnt++;
                if (bit_cnt == 32) begin
                    check_header();
                end
            end
            sclk_q = spi_sclk;
            cs_q   = cs_low;
            if (pending) begin
                latency++;
            end
            if (mem_ready) begin
                finish_entry();
            end
            if (mem_we || mem_re) begin
                started    = 1'b1;
                pending    = 1'b1;
                req_addr   = mem_addr;
                is_write   = mem_we;
                to_psram   = mem_addr[31:24] == PSRAM_BASE[31:24];
                is_mem     = to_psram || mem_addr[31:24] == FLASH_BASE[31:24];
                exp_q      = exp_rdata;
                check_q    = exp_check;
                hdr_seen   = 1'b0;
                latency    = 0;
                entry_errs = 0;
            end
        end
    end

endmodule

// ==== dv/tb_top.sv ====
// Memory controller testbench
`timescale 1ns/1ps
`include "memctl_cfg.svh"

module tb_top
    import memctl_bus_pkg::*;
();
    localparam int         MAX_ENTRIES = 32;
    localparam logic [7:0] FLASH_FILL  = 8'h3c;
    localparam logic [7:0] PSRAM_FILL  = 8'hc3;
    localparam addr_t      FLASH       = `MEMCTL_FLASH_BASE;
    localparam addr_t      PSRAM       = `MEMCTL_PSRAM_BASE;
    // RISC-V load and store size codes
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;

    logic                          clk;
    logic                          rst_n;
    addr_t                         mem_addr;
    word_t                         mem_wdata;
    logic [2:0]                    mem_flag;
    logic                          mem_we;
    logic                          mem_re;
    word_t                         mem_rdata;
    logic                          mem_ready;
    logic [`MEMCTL_UART_NUM*32-1:0] uart_words;
    word_t                         gpio_word;
    word_t                         timer_word;
    logic                          flash_cs_n;
    logic                          ram_cs_n;
    logic                          spi_sclk;
    logic                          spi_mosi;
    wire                           spi_miso;
    word_t                         exp_rdata;
    logic                          exp_check;
    int                            errors;
    int                            checked;
    int                            cycle_cnt = 0;
    integer                        seed = 32'h75f1be34;

    // Stimulus table
    logic       t_write [MAX_ENTRIES];
    logic [2:0] t_f3    [MAX_ENTRIES];
    addr_t      t_addr  [MAX_ENTRIES];
    word_t      t_wdata [MAX_ENTRIES];
    word_t      t_exp   [MAX_ENTRIES];
    logic       t_check [MAX_ENTRIES];
    int         n_entries = 0;
    logic       table_done = 1'b0;

    // Expected memory contents as little-endian bytes
    logic [7:0] flash_sh [0:255];
    logic [7:0] psram_sh [0:255];

    pulldown (spi_miso);

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mem_ctl_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_flag        (mem_flag),
        .mem_we          (mem_we),
        .mem_re          (mem_re),
        .mem_rdata       (mem_rdata),
        .mem_ready       (mem_ready),
        .uart_mem_rdata  (uart_words),
        .gpio_mem_rdata  (gpio_word),
        .timer_mem_rdata (timer_word),
        .flash_cs_n      (flash_cs_n),
        .ram_cs_n        (ram_cs_n),
        .spi_sclk        (spi_sclk),
        .spi_mosi        (spi_mosi),
        .spi_miso        (spi_miso)
    );

    spi_mem_model #(.FILL(FLASH_FILL)) u_flash (
        .cs_n (flash_cs_n),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .miso (spi_miso)
    );

    spi_mem_model #(.FILL(PSRAM_FILL)) u_psram (
        .cs_n (ram_cs_n),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .miso (spi_miso)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .exp_rdata  (exp_rdata),
        .exp_check  (exp_check),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .errors     (errors),
        .checked    (checked)
    );

    function automatic int byte_count(input logic [2:0] f3);
        case (f3[1:0])
            2'b00: return 1;
            2'b01: return 2;
            default: return 4;
        endcase
    endfunction

    // Bit 24 separates PSRAM from flash
    function automatic logic [7:0] shadow_read(input addr_t a);
        return a[24] ? psram_sh[a[7:0]] : flash_sh[a[7:0]];
    endfunction

    task automatic shadow_write(input addr_t a, input logic [7:0] b);
        if (a[24]) begin
            psram_sh[a[7:0]] = b;
        end else begin
            flash_sh[a[7:0]] = b;
        end
    endtask

    task automatic add_entry(input logic write, input logic [2:0] f3, input addr_t addr,
                             input word_t wdata, input word_t exp, input logic check);
        t_write[n_entries] = write;
        t_f3[n_entries]    = f3;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_exp[n_entries]   = exp;
        t_check[n_entries] = check;
        n_entries++;
    endtask

    task automatic add_store(input logic [2:0] f3, input addr_t addr);
        word_t wd;
        wd = $random(seed);
        for (int i = 0; i < byte_count(f3); i++) begin
            shadow_write(addr + i, wd[8*i +: 8]);
        end
        add_entry(1'b1, f3, addr, wd, '0, 1'b0);
    endtask

    // Unused upper bytes of a load stay zero
    task automatic add_load(input logic [2:0] f3, input addr_t addr);
        word_t exp;
        exp = '0;
        for (int i = 0; i < byte_count(f3); i++) begin
            exp[8*i +: 8] = shadow_read(addr + i);
        end
        add_entry(1'b0, f3, addr, '0, exp, 1'b1);
    endtask

    task automatic build_table();
        addr_t a;
        add_entry(1'b0, F3_W, `MEMCTL_GPIO_BASE, '0, gpio_word, 1'b1);
        add_entry(1'b0, F3_W, `MEMCTL_TIMER_BASE + 32'h4, '0, timer_word, 1'b1);
        for (int i = 0; i < `MEMCTL_UART_NUM; i++) begin
            a = `MEMCTL_UART_BASE + i * 256;
            add_entry(1'b0, F3_W, a, '0, uart_words[32*i +: 32], 1'b1);
        end
        add_entry(1'b1, F3_W, `MEMCTL_GPIO_BASE + 32'h4, $random(seed), '0, 1'b0);
        add_store(F3_W, PSRAM + 32'h10);
        add_load(F3_W, PSRAM + 32'h10);
        add_load(F3_W, FLASH + 32'h10);
        add_store(F3_B, PSRAM + 32'h11);
        add_load(F3_W, PSRAM + 32'h10);
        add_store(F3_H, PSRAM + 32'h16);
        add_load(F3_W, PSRAM + 32'h14);
        add_load(F3_BU, PSRAM + 32'h11);
        add_load(F3_HU, PSRAM + 32'h16);
        // Fill byte at this offset has bit 7 set
        add_load(F3_B, FLASH + 32'h22);
        add_store(F3_W, FLASH + 32'h10);
        add_load(F3_W, FLASH + 32'h10);
        add_load(F3_W, PSRAM + 32'h10);
        add_load(F3_H, FLASH + 32'h12);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (table_done);
        wait (cycle_cnt >= n_entries * 160);
        $display("Timeout after %0d cycles with %0d of %0d entries answered",
                 cycle_cnt, checked, n_entries);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        mem_addr  = '0;
        mem_wdata = '0;
        mem_flag  = 3'd0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        exp_rdata = '0;
        exp_check = 1'b0;
        for (int i = 0; i < `MEMCTL_UART_NUM; i++) begin
            uart_words[32*i +: 32] = $random(seed);
        end
        gpio_word  = $random(seed);
        timer_word = $random(seed);
        for (int i = 0; i < 256; i++) begin
            flash_sh[i] = (i[7:0] * 8'd37) ^ FLASH_FILL;
            psram_sh[i] = (i[7:0] * 8'd37) ^ PSRAM_FILL;
        end
        build_table();
        table_done = 1'b1;

        wait (rst_n);
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk);
            mem_addr  <= t_addr[i];
            mem_wdata <= t_wdata[i];
            mem_flag  <= t_f3[i];
            mem_we    <= t_write[i];
            mem_re    <= !t_write[i];
            exp_rdata <= t_exp[i];
            exp_check <= t_check[i];
            @(posedge clk);
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            do begin
                @(posedge clk);
            end while (!mem_ready);
        end
        @(posedge clk);
        $display("Checked %0d of %0d entries with %0d errors", checked, n_entries, errors);
        if (errors == 0 && checked == n_entries) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/memctl_bus_pkg.sv
logic/memctl_spi_pkg.sv
logic/memctl_ifs.sv
logic/req_decode.sv
logic/access_ctl.sv
logic/spi_shifter.sv
logic/rsp_format.sv
logic/mem_ctl_top.sv
dv/tb_clk_gen.sv
dv/spi_mem_model.sv
dv/tb_checker.sv
dv/tb_top.sv
